/* all.f */
hdl/ramPkg.sv
hdl/asyncFifo.sv
hdl/ramDualClkFifo.sv
hdl/sramInterface.sv
hdl/ramUnit.sv
testbench/sramModel.sv
testbench/tbRamUnit.sv

/* hdl/asyncFifo.sv */
module asyncFifo #(
	parameter int pWidth = 16,
	parameter int pDepth = 16		// Power of two
)(
	// Write side
	input  logic              wrClk,
	input  logic              wrReset,
	input  logic [pWidth-1:0] wrData,
	input  logic              wrEn,
	output logic              full,
	// Read side
	input  logic              rdClk,
	input  logic              rdReset,
	input  logic              rdEn,
	output logic [pWidth-1:0] rdData,		// Show-ahead word
	output logic              empty
);

localparam int cAw = $clog2(pDepth);
// Top two Gray bits flipped when writer is one lap ahead
localparam logic [cAw:0] cFullMask = (cAw + 1)'(3) << (cAw - 1);

logic [pWidth-1:0] mem [pDepth];		// Dual-port storage

logic [cAw:0] wrBin, wrBinNext, wrGray;
logic [cAw:0] rdBin, rdBinNext, rdGray;
logic [cAw:0] rdGraySync1, rdGraySync2;	// Read pointer in wrClk
logic [cAw:0] wrGraySync1, wrGraySync2;	// Write pointer in rdClk
logic         wrPush, rdPop;

//------------------------------
// Write domain
//------------------------------
assign full      = (wrGray == (rdGraySync2 ^ cFullMask));
assign wrPush    = wrEn & ~full;
assign wrBinNext = wrBin + (cAw + 1)'(wrPush);

always_ff @(posedge wrClk)
begin
	if (wrReset)
	begin
		wrBin       <= '0;
		wrGray      <= '0;
		rdGraySync1 <= '0;
		rdGraySync2 <= '0;
	end
	else
	begin
		wrBin       <= wrBinNext;
		wrGray      <= wrBinNext ^ (wrBinNext >> 1);	// Binary to Gray
		rdGraySync1 <= rdGray;							// Two-flop sync
		rdGraySync2 <= rdGraySync1;
	end
end

always_ff @(posedge wrClk)
begin
	if (wrPush)
		mem[wrBin[cAw-1:0]] <= wrData;
end

//------------------------------
// Read domain
//------------------------------
assign empty     = (rdGray == wrGraySync2);
assign rdPop     = rdEn & ~empty;
assign rdBinNext = rdBin + (cAw + 1)'(rdPop);
assign rdData    = mem[rdBin[cAw-1:0]];		// Head of queue

always_ff @(posedge rdClk)
begin
	if (rdReset)
	begin
		rdBin       <= '0;
		rdGray      <= '0;
		wrGraySync1 <= '0;
		wrGraySync2 <= '0;
	end
	else
	begin
		rdBin       <= rdBinNext;
		rdGray      <= rdBinNext ^ (rdBinNext >> 1);
		wrGraySync1 <= wrGray;
		wrGraySync2 <= wrGraySync1;
	end
end

// Callers must honour the flags
assert property (@(posedge wrClk) disable iff (wrReset) !(wrEn && full))
	else $error("asyncFifo write while full");
assert property (@(posedge rdClk) disable iff (rdReset) !(rdEn && empty))
	else $error("asyncFifo read while empty");

endmodule

/* hdl/ramDualClkFifo.sv */
module ramDualClkFifo #(
	parameter int pRamAdrsWidth = 19,
	parameter int pRamFifoDepth = 16
)(
	input  logic                           sysClk,
	input  logic                           memClk,
	input  logic                           reset,
	// Ufi bus side
	input  logic                           ufiValid,
	input  logic                           ufiCmd,		// High read, low write
	input  logic [pRamAdrsWidth-2:0]       ufiAdrs,		// Word address
	input  logic [ramPkg::cBusWidth-1:0]   ufiWd,
	output logic                           ufiReady,
	output logic                           rdValid,
	output logic [ramPkg::cBusWidth-1:0]   rdData,
	input  logic                           rdReady,
	// Sequencer side
	output logic                           cmdValid,
	input  logic                           cmdReady,
	output logic                           cmdWrite,
	output logic [pRamAdrsWidth-2:0]       cmdAdrs,
	output ramPkg::busWordU                cmdData,
	input  logic                           retValid,	// No ready, space held at issue
	input  ramPkg::busWordU                retData
);

localparam int cRecWidth = pRamAdrsWidth - 1 + ramPkg::cRecFixedBits;

logic [cRecWidth-1:0] cmdRec;
logic                 cmdFull, cmdEmpty;
logic                 retFull, retEmpty;

//------------------------------
// Command path sysClk to memClk
//------------------------------
assign ufiReady = ~cmdFull;

asyncFifo #(
	.pWidth		(cRecWidth),
	.pDepth		(pRamFifoDepth)
) u_cmdFifo (
	.wrClk		(sysClk),
	.wrReset	(reset),
	.wrData		({ufiCmd, ufiAdrs, ufiWd}),
	.wrEn		(ufiValid & ufiReady),
	.full		(cmdFull),
	.rdClk		(memClk),
	.rdReset	(reset),
	.rdEn		(cmdValid & cmdReady),
	.rdData		(cmdRec),
	.empty		(cmdEmpty)
);

// Issue only with room for a possible read result
assign cmdValid     = ~cmdEmpty & ~retFull;
assign cmdWrite     = (cmdRec[cRecWidth-1] == ramPkg::cCmdWrite);
assign cmdAdrs      = cmdRec[ramPkg::cRecAdrsLsb +: pRamAdrsWidth-1];
assign cmdData.word = cmdRec[ramPkg::cRecDataLsb +: ramPkg::cBusWidth];

//------------------------------
// Return path memClk to sysClk
//------------------------------
asyncFifo #(
	.pWidth		(ramPkg::cBusWidth),
	.pDepth		(pRamFifoDepth)
) u_retFifo (
	.wrClk		(memClk),
	.wrReset	(reset),
	.wrData		(retData.word),
	.wrEn		(retValid),
	.full		(retFull),
	.rdClk		(sysClk),
	.rdReset	(reset),
	.rdEn		(rdValid & rdReady),
	.rdData		(rdData),		// Held until popped
	.empty		(retEmpty)
);

assign rdValid = ~retEmpty;

endmodule

/* hdl/ramPkg.sv */
package ramPkg;

	//------------------------------
	// Widths
	//------------------------------
	localparam int cBusWidth     = 16;	// Ufi bus word
	localparam int cDqWidth      = 8;	// SRAM DQ
	localparam int cBytesPerWord = cBusWidth / cDqWidth;

	// Command bit on the bus, high read and low write
	localparam logic cCmdRead  = 1'b1;
	localparam logic cCmdWrite = 1'b0;

	//------------------------------
	// Command record {cmd, word address, data}
	//------------------------------
	localparam int cRecDataLsb   = 0;				// Data in the low bits
	localparam int cRecAdrsLsb   = cBusWidth;		// Word address above data
	localparam int cRecFixedBits = cBusWidth + 1;	// Record width without address

	// One bus word, seen whole or as its SRAM bytes
	typedef union packed
	{
		logic [cBusWidth-1:0]                   word;
		logic [cBytesPerWord-1:0][cDqWidth-1:0] bytes;	// Index 0 is the low byte
	} busWordU;

endpackage

/* hdl/ramUnit.sv */
module ramUnit #(
	parameter int pRamAdrsWidth = 19,		// Byte address
	parameter int pRamFifoDepth = 16,
	parameter int pAccessCycles = 2
)(
	input  logic                          sysClk,
	input  logic                          memClk,
	input  logic                          reset,
	// Ufi bus write
	input  logic                          ufiValid,
	input  logic                          ufiCmd,
	input  logic [pRamAdrsWidth-2:0]      ufiAdrs,		// Word address
	input  logic [ramPkg::cBusWidth-1:0]  ufiWd,
	output logic                          ufiReady,
	// Ufi bus read return
	output logic                          rdValid,
	output logic [ramPkg::cBusWidth-1:0]  rdData,
	input  logic                          rdReady,
	// SRAM, DQ split for the pad outside
	output logic [pRamAdrsWidth-1:0]      memAdrs,
	output logic                          memCeN,
	output logic                          memOeN,
	output logic                          memWeN,
	output logic [ramPkg::cDqWidth-1:0]   dqOut,
	input  logic [ramPkg::cDqWidth-1:0]   dqIn,
	output logic                          dqOe
);

//------------------------------
// Memory clock handshake wires
//------------------------------
logic                     cmdValid, cmdReady, cmdWrite;
logic [pRamAdrsWidth-2:0] cmdAdrs;
ramPkg::busWordU          cmdData;
logic                     retValid;
ramPkg::busWordU          retData;

ramDualClkFifo #(
	.pRamAdrsWidth	(pRamAdrsWidth),
	.pRamFifoDepth	(pRamFifoDepth)
) u_ramDualClkFifo (
	.sysClk		(sysClk),
	.memClk		(memClk),
	.reset		(reset),
	.ufiValid	(ufiValid),
	.ufiCmd		(ufiCmd),
	.ufiAdrs	(ufiAdrs),
	.ufiWd		(ufiWd),
	.ufiReady	(ufiReady),
	.rdValid	(rdValid),
	.rdData		(rdData),
	.rdReady	(rdReady),
	.cmdValid	(cmdValid),
	.cmdReady	(cmdReady),
	.cmdWrite	(cmdWrite),
	.cmdAdrs	(cmdAdrs),
	.cmdData	(cmdData),
	.retValid	(retValid),
	.retData	(retData)
);

sramInterface #(
	.pRamAdrsWidth	(pRamAdrsWidth),
	.pAccessCycles	(pAccessCycles)
) u_sramInterface (
	.memClk		(memClk),
	.reset		(reset),
	.cmdValid	(cmdValid),
	.cmdReady	(cmdReady),
	.cmdWrite	(cmdWrite),
	.cmdAdrs	(cmdAdrs),
	.cmdData	(cmdData),
	.retValid	(retValid),
	.retData	(retData),
	.memAdrs	(memAdrs),
	.memCeN		(memCeN),
	.memOeN		(memOeN),
	.memWeN		(memWeN),
	.dqOut		(dqOut),
	.dqIn		(dqIn),
	.dqOe		(dqOe)
);

endmodule

/* hdl/sramInterface.sv */
module sramInterface #(
	parameter int pRamAdrsWidth = 19,
	parameter int pAccessCycles = 2		// memClks per strobe
)(
	input  logic                          memClk,
	input  logic                          reset,
	// Command in
	input  logic                          cmdValid,
	output logic                          cmdReady,
	input  logic                          cmdWrite,
	input  logic [pRamAdrsWidth-2:0]      cmdAdrs,
	input  ramPkg::busWordU               cmdData,
	// Read word out
	output logic                          retValid,
	output ramPkg::busWordU               retData,
	// SRAM pins
	output logic [pRamAdrsWidth-1:0]      memAdrs,
	output logic                          memCeN,
	output logic                          memOeN,
	output logic                          memWeN,
	output logic [ramPkg::cDqWidth-1:0]   dqOut,
	input  logic [ramPkg::cDqWidth-1:0]   dqIn,
	output logic                          dqOe
);

localparam int cCntWidth = (pAccessCycles > 1) ? $clog2(pAccessCycles) : 1;
localparam logic [1:0] sIdle   = 2'd0;
localparam logic [1:0] sStrobe = 2'd1;	// Strobe held low
localparam logic [1:0] sGap    = 2'd2;	// All strobes high

logic [1:0]               state;
logic                     byteSel;		// 0 low byte, 1 high byte
logic [cCntWidth-1:0]     accCnt;
logic                     isWrite;
logic [pRamAdrsWidth-2:0] wordAdrs;
ramPkg::busWordU          wrWord;
ramPkg::busWordU          rdWord;
logic                     accept, strobeDone, startHigh;

assign cmdReady   = (state == sIdle);	// One command in flight
assign accept     = cmdValid & cmdReady;
assign strobeDone = (state == sStrobe) && (accCnt == cCntWidth'(pAccessCycles - 1));
assign startHigh  = (state == sGap) && !byteSel;
assign retData    = rdWord;

//------------------------------
// Sequencer and strobes
//------------------------------
always_ff @(posedge memClk)
begin
	if (reset)
	begin
		state    <= sIdle;
		byteSel  <= 1'b0;
		accCnt   <= '0;
		memCeN   <= 1'b1;
		memOeN   <= 1'b1;
		memWeN   <= 1'b1;
		dqOe     <= 1'b0;
		retValid <= 1'b0;
	end
	else
	begin
		retValid <= strobeDone & byteSel & ~isWrite;	// Lands in the last gap
		if (accept || startHigh)
		begin
			state   <= sStrobe;
			byteSel <= startHigh;
			accCnt  <= '0;
			memCeN  <= 1'b0;
			memOeN  <= accept ? cmdWrite : isWrite;		// OE on reads
			memWeN  <= accept ? ~cmdWrite : ~isWrite;	// WE on writes
			dqOe    <= accept ? cmdWrite : isWrite;
		end
		else if (strobeDone)
		begin
			state  <= sGap;
			memCeN <= 1'b1;
			memOeN <= 1'b1;
			memWeN <= 1'b1;
			dqOe   <= 1'b0;
		end
		else if (state == sStrobe)
			accCnt <= accCnt + 1'b1;
		else if (state == sGap)
			state <= sIdle;		// Gap after high byte
	end
end

//------------------------------
// Address and data path
//------------------------------
always_ff @(posedge memClk)
begin
	if (accept)
	begin
		isWrite  <= cmdWrite;
		wordAdrs <= cmdAdrs;
		wrWord   <= cmdData;
		memAdrs  <= {cmdAdrs, 1'b0};		// Even byte first
		dqOut    <= cmdData.bytes[0];
	end
	else if (startHigh)
	begin
		memAdrs <= {wordAdrs, 1'b1};
		dqOut   <= wrWord.bytes[1];
	end
	if (strobeDone && !isWrite)
		rdWord.bytes[byteSel] <= dqIn;	// Sample on last strobe cycle
end

// SRAM bus rules
assert property (@(posedge memClk) disable iff (reset) !(!memOeN && !memWeN))
	else $error("sramInterface OE and WE low together");
assert property (@(posedge memClk) disable iff (reset) dqOe == (!memWeN && !memCeN))
	else $error("sramInterface DQ drive outside write strobe");

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the ramUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbRamUnit -f all.f -o simTbRamUnit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi
./obj_dir/simTbRamUnit
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi
exit 0

/* testbench/ramUnit_testdata.txt */
# op wordAdrs data : W writes data, R reads and expects data (all hex)
# H cycles 0 holds rdReady low, X pairs 0 runs random write/read pairs
W 00010 1234
R 00010 1234
W 00011 a55a
W 3ffff beef
R 00011 a55a
R 3ffff beef
W 00020 c0de
W 00021 0f0f
W 00022 8001
W 00023 7ffe
R 00020 c0de
R 00021 0f0f
R 00022 8001
R 00023 7ffe
H 3c 0
R 00020 c0de
R 00021 0f0f
R 00022 8001
R 00023 7ffe
R 00010 1234
R 00011 a55a
R 3ffff beef
R 00020 c0de
R 00021 0f0f
R 00022 8001
X 14 0

/* testbench/sramModel.sv */
module sramModel #(
	parameter int pAdrsWidth = 19		// Byte address
)(
	input  logic                        memClk,
	input  logic [pAdrsWidth-1:0]       memAdrs,
	input  logic                        memCeN,
	input  logic                        memOeN,
	input  logic                        memWeN,
	input  logic [ramPkg::cDqWidth-1:0] dqOut,
	input  logic                        dqOe,
	output logic [ramPkg::cDqWidth-1:0] dqIn,
	output logic                        protocolErr	// Sticky strobe rule violation
);

timeunit 1ns;
timeprecision 100ps;

logic [ramPkg::cDqWidth-1:0] mem [2**pAdrsWidth];	// Byte array
logic                        clash = 1'b0;

//------------------------------
// Pad side of the split DQ bus
//------------------------------
assign dqIn        = (!memCeN && !memOeN) ? mem[memAdrs] : '0;	// Floats low when not read
assign protocolErr = clash;

// Strobes settle by the falling memClk edge
always @(negedge memClk)
begin
	if (!memCeN && !memWeN && dqOe)
		mem[memAdrs] <= dqOut;
	if (!memOeN && !memWeN)
		clash <= 1'b1;		// OE and WE together
	if (!memWeN && !dqOe)
		clash <= 1'b1;		// Write strobe with DQ undriven
end

endmodule

/* testbench/tbRamUnit.sv */
module tbRamUnit;

timeunit 1ns;
timeprecision 100ps;

localparam int    cAdrsWidth     = 19;
localparam int    cWordAdrsWidth = cAdrsWidth - 1;
localparam int    cResetCycles   = 10;
localparam int    cCyclesPerOp   = 200;		// Budget per line and per random pair
localparam string cDataFile      = "testbench/ramUnit_testdata.txt";

logic                          sysClk, memClk, reset;
logic                          ufiValid, ufiCmd, ufiReady;
logic [cWordAdrsWidth-1:0]     ufiAdrs;
logic [ramPkg::cBusWidth-1:0]  ufiWd;
logic                          rdValid, rdReady;
logic [ramPkg::cBusWidth-1:0]  rdData;
logic [cAdrsWidth-1:0]         memAdrs;
logic                          memCeN, memOeN, memWeN, dqOe, protocolErr;
logic [ramPkg::cDqWidth-1:0]   dqOut, dqIn;

byte                           opList[$];			// Parsed data file
logic [31:0]                   argAList[$], argBList[$];
logic [ramPkg::cBusWidth-1:0]  shadow [2**cWordAdrsWidth];	// Tracks every accepted write
logic [cWordAdrsWidth-1:0]     expAdrs[$];			// Scoreboard, issue order
ramPkg::busWordU               expWord[$];
bit                            expBytes[$];			// Also check SRAM bytes
int                            cycleCnt, cycleLimit, holdCnt;
integer                        seed = 47;
bit                            holdUsed, stallSeen, heldPrev;
ramPkg::busWordU               heldWord;

initial
begin
	sysClk = 1'b0;
	forever #50 sysClk = ~sysClk;
end

initial
begin
	memClk = 1'b0;
	forever #35 memClk = ~memClk;		// Unrelated to sysClk
end

ramUnit #(
	.pRamAdrsWidth	(cAdrsWidth),
	.pRamFifoDepth	(4),		// Small, back-pressure comes fast
	.pAccessCycles	(2)
) u_ramUnit (
	.sysClk		(sysClk),
	.memClk		(memClk),
	.reset		(reset),
	.ufiValid	(ufiValid),
	.ufiCmd		(ufiCmd),
	.ufiAdrs	(ufiAdrs),
	.ufiWd		(ufiWd),
	.ufiReady	(ufiReady),
	.rdValid	(rdValid),
	.rdData		(rdData),
	.rdReady	(rdReady),
	.memAdrs	(memAdrs),
	.memCeN		(memCeN),
	.memOeN		(memOeN),
	.memWeN		(memWeN),
	.dqOut		(dqOut),
	.dqIn		(dqIn),
	.dqOe		(dqOe)
);

sramModel #(
	.pAdrsWidth	(cAdrsWidth)
) u_sramModel (
	.memClk		(memClk),
	.memAdrs	(memAdrs),
	.memCeN		(memCeN),
	.memOeN		(memOeN),
	.memWeN		(memWeN),
	.dqOut		(dqOut),
	.dqOe		(dqOe),
	.dqIn		(dqIn),
	.protocolErr	(protocolErr)
);

//------------------------------
// Failure and compare tasks
//------------------------------
task automatic abortRun(input string why);
	$display("%s", why);
	$display("=== FAIL ===");
	$fatal(1, "run stopped at first error");
endtask

task automatic checkWord(input string name, input ramPkg::busWordU got,
		input ramPkg::busWordU exp);
	if (got.word !== exp.word)
	begin
		$display("ERR %0t %s got %h expected %h", $time, name, got.word, exp.word);
		abortRun("word mismatch");
	end
endtask

task automatic checkByte(input string name, input logic [ramPkg::cDqWidth-1:0] got,
		input logic [ramPkg::cDqWidth-1:0] exp);
	if (got !== exp)
	begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		abortRun("SRAM byte mismatch");
	end
endtask

task automatic checkFlag(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		abortRun("control flag mismatch");
	end
endtask

always @(negedge memClk)
begin
	if (protocolErr)
		abortRun("SRAM strobe rule broken, OE with WE low or write without DQ drive");
end

//------------------------------
// One sysClk, read side serviced
//------------------------------
task automatic advanceCycle();
	logic [cWordAdrsWidth-1:0] adrs;
	ramPkg::busWordU           exp;
	bit                        withBytes;
	rdReady = (holdCnt == 0);
	if (holdCnt > 0)
	begin
		if (ufiValid && !ufiReady)
			stallSeen = 1'b1;		// Back-pressure reached the bus
		holdCnt--;
	end
	if (heldPrev)
	begin
		checkFlag("rdValid", rdValid, 1'b1);	// Must hold while stalled
		checkWord("rdData", rdData, heldWord);
	end
	if (rdValid && rdReady)			// Pops on the coming edge
	begin
		if (expWord.size() == 0)
			abortRun("read result arrived with no read outstanding");
		else
		begin
			exp       = expWord.pop_front();
			adrs      = expAdrs.pop_front();
			withBytes = expBytes.pop_front();
			checkWord("rdData", rdData, exp);
			if (withBytes)
			begin
				checkByte("sram low byte", u_sramModel.mem[{adrs, 1'b0}], exp.bytes[0]);
				checkByte("sram high byte", u_sramModel.mem[{adrs, 1'b1}], exp.bytes[1]);
			end
		end
	end
	heldPrev = rdValid && !rdReady;
	heldWord = rdData;
	@(posedge sysClk);
	#10;		// Drive point, DUT outputs settled
	cycleCnt++;
	if (cycleCnt > cycleLimit)
		abortRun($sformatf("timeout, run exceeded %0d sysClk cycles", cycleLimit));
endtask

// Holds the request until the bus takes it
task automatic sendRequest(input logic cmd, input logic [cWordAdrsWidth-1:0] adrs,
		input logic [ramPkg::cBusWidth-1:0] data);
	bit taken;
	ufiValid = 1'b1;
	ufiCmd   = cmd;
	ufiAdrs  = adrs;
	ufiWd    = data;
	taken    = 1'b0;
	while (!taken)
	begin
		taken = ufiReady;		// Stable until the next edge
		advanceCycle();
	end
	ufiValid = 1'b0;
endtask

task automatic writeWord(input logic [cWordAdrsWidth-1:0] adrs,
		input logic [ramPkg::cBusWidth-1:0] data);
	sendRequest(ramPkg::cCmdWrite, adrs, data);
	shadow[adrs] = data;
endtask

task automatic readWord(input logic [cWordAdrsWidth-1:0] adrs, input ramPkg::busWordU exp,
		input bit withBytes);
	sendRequest(ramPkg::cCmdRead, adrs, '0);
	expAdrs.push_back(adrs);
	expWord.push_back(exp);
	expBytes.push_back(withBytes);
endtask

//------------------------------
// Main sequence
//------------------------------
initial
begin
	int          fd, code, i, k;
	byte         opChar;
	logic [31:0] argA, argB, rnd;
	logic [8*128-1:0] lineBuf;
	reset    = 1'b1;
	ufiValid = 1'b0;
	ufiCmd   = 1'b0;
	ufiAdrs  = '0;
	ufiWd    = '0;
	rdReady  = 1'b0;
	cycleCnt = 0;
	holdCnt  = 0;
	holdUsed = 1'b0;
	stallSeen = 1'b0;
	heldPrev = 1'b0;
	cycleLimit = 20;		// Tail after the drain

	fd = $fopen(cDataFile, "r");
	if (fd == 0)
		abortRun("cannot open the stimulus data file");
	while (!$feof(fd))
	begin
		code = $fscanf(fd, " %c", opChar);
		if (code != 1)
			break;
		if (opChar == "#")
		begin
			code = $fgets(lineBuf, fd);	// Column notes
			continue;
		end
		code = $fscanf(fd, "%h %h", argA, argB);
		if (code != 2)
			abortRun("malformed operation line in the data file");
		opList.push_back(opChar);
		argAList.push_back(argA);
		argBList.push_back(argB);
		cycleLimit += cCyclesPerOp;
		if (opChar == "X")
			cycleLimit += cCyclesPerOp * int'(argA);
	end
	$fclose(fd);

	repeat (cResetCycles) @(posedge sysClk);
	#10;
	reset = 1'b0;

	// Idle state right after reset
	checkFlag("ufiReady", ufiReady, 1'b1);
	checkFlag("rdValid", rdValid, 1'b0);
	checkFlag("memCeN", memCeN, 1'b1);
	checkFlag("memOeN", memOeN, 1'b1);
	checkFlag("memWeN", memWeN, 1'b1);
	checkFlag("dqOe", dqOe, 1'b0);

	for (i = 0; i < opList.size(); i++)
	begin
		argA = argAList[i];
		argB = argBList[i];
		case (opList[i])
			"W": writeWord(argA[cWordAdrsWidth-1:0], argB[ramPkg::cBusWidth-1:0]);
			"R":
			begin
				checkWord("data file word vs shadow", shadow[argA[cWordAdrsWidth-1:0]],
					argB[ramPkg::cBusWidth-1:0]);
				readWord(argA[cWordAdrsWidth-1:0], argB[ramPkg::cBusWidth-1:0], 1'b1);
			end
			"H":
			begin
				holdCnt  = int'(argA);	// rdReady low from the next cycle
				holdUsed = 1'b1;
			end
			"X":
			begin
				for (k = 0; k < int'(argA); k++)
				begin
					rnd  = $random(seed);
					argB = $random(seed);
					writeWord(rnd[cWordAdrsWidth-1:0], argB[ramPkg::cBusWidth-1:0]);
					readWord(rnd[cWordAdrsWidth-1:0], shadow[rnd[cWordAdrsWidth-1:0]], 1'b0);
				end
			end
			default: abortRun("unknown operation letter in the data file");
		endcase
	end

	while (expWord.size() > 0)
		advanceCycle();
	repeat (20) advanceCycle();		// Nothing extra may show up
	checkFlag("rdValid", rdValid, 1'b0);

	if (holdUsed && !stallSeen)
		abortRun("ufiReady never dropped while rdReady was held low");
	else
	begin
		$display("=== PASS ===");
		$finish;
	end
end

endmodule
